//--- design/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

  // ==========================================================================
  // word and field types
  // ==========================================================================

  // data word and byte address
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0]  regAddr_t;
  // major opcode, bits 31..26
  typedef logic [5:0]  opcode_t;
  // r-type function, bits 5..0
  typedef logic [5:0]  funct_t;

  // ==========================================================================
  // encodings
  // ==========================================================================

  // opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // funct codes, only meaningful under OP_RTYPE
  localparam funct_t FN_SLL = 6'h00;
  localparam funct_t FN_SRL = 6'h02;
  localparam funct_t FN_JR  = 6'h08;
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // jal link target, r31
  localparam regAddr_t LINK_REG = 5'd31;

  // alu operation classes
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_NONE
  } aluOp_t;

endpackage

`default_nettype wire

//--- design/mipsMemPkg.sv
`default_nettype none

package mipsMemPkg;

  // data memory word address width, 128 words
  localparam int DMEM_ADDR_W_DEF = 7;

  // byte offset bits below the word address
  localparam int BYTE_OFS_W = 2;

  // first fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import mipsIsaPkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output logic    regDst,
  output logic    aluSrc,
  output logic    memToReg,
  output logic    regWrite,
  output logic    memRead,
  output logic    memWrite,
  output logic    branch,
  output logic    jump,
  output logic    jumpReg,
  output logic    link,
  output logic    shiftOp,
  output aluOp_t  aluOp
);

  // ==========================================================================
  // single decode table
  // ==========================================================================

  always_comb begin
    // defaults give a no-op, nothing written
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    jumpReg  = 1'b0;
    link     = 1'b0;
    shiftOp  = 1'b0;
    aluOp    = ALU_NONE;
    case (opcode)
      OP_RTYPE: begin
        // rd is the destination for all r-type writes
        regDst = 1'b1;
        case (funct)
          FN_ADD: begin regWrite = 1'b1; aluOp = ALU_ADD; end
          FN_SUB: begin regWrite = 1'b1; aluOp = ALU_SUB; end
          FN_AND: begin regWrite = 1'b1; aluOp = ALU_AND; end
          FN_OR:  begin regWrite = 1'b1; aluOp = ALU_OR;  end
          FN_SLT: begin regWrite = 1'b1; aluOp = ALU_SLT; end
          FN_SLL: begin regWrite = 1'b1; shiftOp = 1'b1; aluOp = ALU_SLL; end
          FN_SRL: begin regWrite = 1'b1; shiftOp = 1'b1; aluOp = ALU_SRL; end
          // register jump, no write back
          FN_JR:  jumpReg = 1'b1;
          default: ;
        endcase
      end
      OP_LW: begin
        // base plus offset, load data to rt
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
        aluOp    = ALU_ADD;
      end
      OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluOp    = ALU_ADD;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        branch = 1'b1;
        aluOp  = ALU_SUB;
      end
      OP_J:   jump = 1'b1;
      OP_JAL: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsIsaPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     wrEn,
  input  regAddr_t rdAddrA,
  input  regAddr_t rdAddrB,
  input  regAddr_t wrAddr,
  input  word_t    wrData,
  output word_t    rdDataA,
  output word_t    rdDataB
);

  // 32 general registers
  word_t regs [0:31];

  // write port, r0 never written
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // async read ports
  // r0 forced to zero
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mipsIsaPkg::*; (
  input  word_t  opA,
  input  word_t  opB,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  // shift distance from low bits of opA
  logic [4:0] shamt;
  // signed compare for slt
  logic       lessThan;

  assign shamt    = opA[4:0];
  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (op)
      ALU_ADD: result = opA + opB;
      ALU_SUB: result = opA - opB;
      ALU_AND: result = opA & opB;
      ALU_OR:  result = opA | opB;
      ALU_SLT: result = {31'b0, lessThan};
      // shifts act on opB
      ALU_SLL: result = opB << shamt;
      ALU_SRL: result = opB >> shamt;
      default: result = '0;
    endcase
  end

  // zero flag for every op, beq uses it after sub
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit import mipsIsaPkg::*, mipsMemPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        branchTaken,
  input  logic        jump,
  input  logic        jumpReg,
  input  word_t       branchOfs,
  input  logic [25:0] jumpIndex,
  input  word_t       regTarget,
  output word_t       pc,
  output word_t       pcPlus4
);

  word_t pcNext;
  word_t branchTarget;
  word_t jumpTarget;

  assign pcPlus4 = pc + 32'd4;

  // branch is relative to the following instruction
  assign branchTarget = pcPlus4 + {branchOfs[29:0], 2'b00};

  // region bits kept from pc plus 4
  assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

  // ==========================================================================
  // next pc, register jump first
  // ==========================================================================

  always_comb begin
    if (jumpReg) begin
      pcNext = regTarget;
    end else if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- design/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsIsaPkg::*, mipsMemPkg::*; #(
  parameter int DMEM_ADDR_W = 7
) (
  input  logic                   clk,
  input  logic                   rst,
  input  word_t                  instr,
  input  word_t                  memRdData,
  output word_t                  imemAddr,
  output logic                   memCen,
  output logic                   memWen,
  output logic [DMEM_ADDR_W-1:0] memAddr,
  output word_t                  memWrData,
  output logic                   wbEn,
  output regAddr_t               wbAddr,
  output word_t                  wbData
);

  // ==========================================================================
  // instruction fields
  // ==========================================================================

  opcode_t     opcode;
  funct_t      funct;
  regAddr_t    rs;
  regAddr_t    rt;
  regAddr_t    rd;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [25:0] jumpIndex;
  word_t       immExt;

  assign opcode    = instr[31:26];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign shamt     = instr[10:6];
  assign funct     = instr[5:0];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];

  // sign extension of the 16-bit offset
  assign immExt = {{16{imm[15]}}, imm};

  // control
  logic   regDst, aluSrc, memToReg, regWrite, memRead, memWrite;
  logic   branch, jump, jumpReg, link, shiftOp;
  aluOp_t aluOp;

  // datapath nets
  word_t    rdDataA, rdDataB;
  word_t    aluA, aluB, aluResult;
  logic     aluZero;
  word_t    pc, pcPlus4;
  regAddr_t wrAddr;
  word_t    wrData;

  controlUnit i_controlUnit (
    .opcode  (opcode),
    .funct   (funct),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .memToReg(memToReg),
    .regWrite(regWrite),
    .memRead (memRead),
    .memWrite(memWrite),
    .branch  (branch),
    .jump    (jump),
    .jumpReg (jumpReg),
    .link    (link),
    .shiftOp (shiftOp),
    .aluOp   (aluOp)
  );

  regFile i_regFile (
    .clk    (clk),
    .rst    (rst),
    .wrEn   (regWrite),
    .rdAddrA(rs),
    .rdAddrB(rt),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB)
  );

  // ==========================================================================
  // operands and alu
  // ==========================================================================

  // shift amount replaces rs for sll/srl
  assign aluA = shiftOp ? {27'b0, shamt} : rdDataA;
  assign aluB = aluSrc ? immExt : rdDataB;

  alu i_alu (
    .opA   (aluA),
    .opB   (aluB),
    .op    (aluOp),
    .result(aluResult),
    .zero  (aluZero)
  );

  pcUnit i_pcUnit (
    .clk        (clk),
    .rst        (rst),
    .branchTaken(branch & aluZero),
    .jump       (jump),
    .jumpReg    (jumpReg),
    .branchOfs  (immExt),
    .jumpIndex  (jumpIndex),
    .regTarget  (rdDataA),
    .pc         (pc),
    .pcPlus4    (pcPlus4)
  );

  assign imemAddr = pc;

  // ==========================================================================
  // write back
  // ==========================================================================

  // link wins over rd/rt
  assign wrAddr = link ? LINK_REG : (regDst ? rd : rt);
  assign wrData = link ? pcPlus4 : (memToReg ? memRdData : aluResult);

  // trace port mirrors the register write
  assign wbEn   = regWrite;
  assign wbAddr = wrAddr;
  assign wbData = wrData;

  // data memory strobes, active low
  assign memCen    = ~(memRead | memWrite);
  assign memWen    = ~memWrite;
  assign memAddr   = aluResult[BYTE_OFS_W +: DMEM_ADDR_W];
  assign memWrData = rdDataB;

endmodule

`default_nettype wire

//--- design/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam import mipsIsaPkg::*, mipsMemPkg::*; #(
  parameter int ADDR_W = DMEM_ADDR_W_DEF
) (
  input  logic              clk,
  input  logic              cen,
  input  logic              wen,
  input  logic [ADDR_W-1:0] addr,
  input  word_t             wrData,
  output word_t             rdData
);

  // word storage
  word_t mem [0:(2**ADDR_W)-1];

  // write needs both strobes low
  always_ff @(posedge clk) begin
    if (!cen && !wen) begin
      mem[addr] <= wrData;
    end
  end

  // combinational read
  assign rdData = mem[addr];

endmodule

`default_nettype wire

//--- design/mipsSystem.sv
`timescale 1ns/1ps
`default_nettype none

module mipsSystem import mipsIsaPkg::*, mipsMemPkg::*; #(
  parameter int DMEM_ADDR_W = DMEM_ADDR_W_DEF
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    instr,
  output word_t    imemAddr,
  output logic     wbEn,
  output regAddr_t wbAddr,
  output word_t    wbData
);

  // core to data memory
  logic                   memCen;
  logic                   memWen;
  logic [DMEM_ADDR_W-1:0] memAddr;
  word_t                  memWrData;
  word_t                  memRdData;

  mipsCore #(
    .DMEM_ADDR_W(DMEM_ADDR_W)
  ) i_mipsCore (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .memRdData(memRdData),
    .imemAddr (imemAddr),
    .memCen   (memCen),
    .memWen   (memWen),
    .memAddr  (memAddr),
    .memWrData(memWrData),
    .wbEn     (wbEn),
    .wbAddr   (wbAddr),
    .wbData   (wbData)
  );

  dataRam #(
    .ADDR_W(DMEM_ADDR_W)
  ) i_dataRam (
    .clk   (clk),
    .cen   (memCen),
    .wen   (memWen),
    .addr  (memAddr),
    .wrData(memWrData),
    .rdData(memRdData)
  );

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // active-low reset, let go just after a rising edge
  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/mipsSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsSystemTb import mipsIsaPkg::*, mipsMemPkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int PROG_WORDS   = 1024;
  localparam int MEM_WORDS    = 1 << DMEM_ADDR_W_DEF;
  // r1 holds the constant one after setup
  localparam int ONE_REG      = 1;

  logic     clk;
  logic     rst;
  word_t    instr;
  word_t    imemAddr;
  logic     wbEn;
  regAddr_t wbAddr;
  word_t    wbData;

  clockGen #(
    .HALF_PERIOD (CLK_PERIOD / 2),
    .RESET_CYCLES(RESET_CYCLES)
  ) i_clockGen (
    .clk(clk),
    .rst(rst)
  );

  mipsSystem #(
    .DMEM_ADDR_W(DMEM_ADDR_W_DEF)
  ) i_mipsSystem (
    .clk     (clk),
    .rst     (rst),
    .instr   (instr),
    .imemAddr(imemAddr),
    .wbEn    (wbEn),
    .wbAddr  (wbAddr),
    .wbData  (wbData)
  );

  // ==========================================================================
  // program store, reference model, prediction
  // ==========================================================================

  word_t    prog [0:PROG_WORDS-1];
  int       emitPtr;
  logic     buildDone;
  string    testName [$];
  word_t    testEnd [$];
  word_t    mRegs [0:31];
  word_t    mMem [0:MEM_WORDS-1];
  word_t    mPc;
  word_t    expPc;
  logic     expWbEn;
  regAddr_t expWbAddr;
  word_t    expWbData;
  logic     checkActive;
  int       errCount;
  int       cycleCount;
  integer   seed;

  function automatic word_t encodeR(input int rs, input int rt, input int rd,
                                    input int sh, input funct_t fn);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t encodeI(input opcode_t op, input int rs, input int rt,
                                    input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // index is a word address
  function automatic word_t encodeJ(input opcode_t op, input int index);
    return {op, 26'(index)};
  endfunction

  task automatic emit(input word_t w);
    if (emitPtr < PROG_WORDS) begin
      prog[emitPtr] = w;
    end
    emitPtr++;
  endtask

  // builds a constant bit by bit from r1, msb first
  task automatic loadConst(input int dst, input word_t value);
    logic started;
    started = 1'b0;
    emit(encodeR(dst, 0, dst, 0, FN_AND));
    for (int b = 31; b >= 0; b--) begin
      if (started) emit(encodeR(0, dst, dst, 1, FN_SLL));
      if (value[b]) begin
        emit(encodeR(dst, ONE_REG, dst, 0, FN_OR));
        started = 1'b1;
      end
    end
  endtask

  // test ends when pc reaches the next free slot
  task automatic markTest(input string name);
    testName.push_back(name);
    testEnd.push_back(word_t'(emitPtr * 4));
  endtask

  task automatic writeReg(input regAddr_t addr, input word_t value);
    expWbEn   = 1'b1;
    expWbAddr = addr;
    expWbData = value;
    if (addr != 5'd0) mRegs[addr] = value;
  endtask

  // one instruction of the model: prediction first, then state update
  task automatic predictInstr(input word_t ins);
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    pc4;
    word_t    nextPc;
    word_t    addr;
    rs        = ins[25:21];
    rt        = ins[20:16];
    rd        = ins[15:11];
    imm       = {{16{ins[15]}}, ins[15:0]};
    a         = mRegs[rs];
    b         = mRegs[rt];
    pc4       = mPc + 32'd4;
    nextPc    = pc4;
    expPc     = mPc;
    expWbEn   = 1'b0;
    expWbAddr = '0;
    expWbData = '0;
    addr      = a + imm;
    case (ins[31:26])
      OP_RTYPE: begin
        case (ins[5:0])
          FN_ADD: writeReg(rd, a + b);
          FN_SUB: writeReg(rd, a - b);
          FN_AND: writeReg(rd, a & b);
          FN_OR:  writeReg(rd, a | b);
          FN_SLT: writeReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          FN_SLL: writeReg(rd, b << ins[10:6]);
          FN_SRL: writeReg(rd, b >> ins[10:6]);
          FN_JR:  nextPc = a;
          default: ;
        endcase
      end
      OP_LW:  writeReg(rt, mMem[addr[BYTE_OFS_W +: DMEM_ADDR_W_DEF]]);
      OP_SW:  mMem[addr[BYTE_OFS_W +: DMEM_ADDR_W_DEF]] = b;
      OP_BEQ: if (a == b) nextPc = pc4 + (imm << 2);
      OP_J:   nextPc = {pc4[31:28], ins[25:0], 2'b00};
      OP_JAL: begin
        nextPc = {pc4[31:28], ins[25:0], 2'b00};
        writeReg(LINK_REG, pc4);
      end
      default: ;
    endcase
    mPc = nextPc;
  endtask

  // instruction goes out 1 ns after the edge, checks land on the falling edge
  task automatic stepCycle();
    int    idx;
    word_t ins;
    idx = int'(imemAddr >> 2);
    ins = '0;
    if (idx >= 0 && idx < emitPtr && idx < PROG_WORDS) ins = prog[idx];
    instr = ins;
    predictInstr(ins);
    checkActive = 1'b1;
    cycleCount++;
    @(posedge clk);
    #1;
  endtask

  task automatic runBlock(input string name, input word_t endAddr);
    int startErr;
    int n;
    startErr = errCount;
    n = 0;
    while (mPc != endAddr && n < PROG_WORDS) begin
      stepCycle();
      n++;
    end
    if (mPc != endAddr) begin
      errCount++;
      $display("test %s never reached its end address 0x%08h", name, endAddr);
    end
    $display("test %-8s %4d cycles, %0d errors", name, n, errCount - startErr);
  endtask

  // ==========================================================================
  // checks
  // ==========================================================================

  assert property (@(negedge clk) rst || (imemAddr == 32'h0))
    else begin
      errCount++;
      $display("ERR %0t: imemAddr 0x%08h during reset, expected 0", $time, imemAddr);
    end

  assert property (@(negedge clk) disable iff (!rst || !checkActive) imemAddr == expPc)
    else begin
      errCount++;
      $display("ERR %0t: imemAddr 0x%08h, expected 0x%08h", $time, imemAddr, expPc);
    end

  assert property (@(negedge clk) disable iff (!rst || !checkActive)
                   (wbEn == expWbEn) &&
                   (!expWbEn || (wbAddr == expWbAddr && wbData == expWbData)))
    else begin
      errCount++;
      $display("ERR %0t: wb %b r%0d 0x%08h, expected %b r%0d 0x%08h at pc 0x%08h",
               $time, wbEn, wbAddr, wbData, expWbEn, expWbAddr, expWbData, expPc);
    end

  // ==========================================================================
  // program build and run
  // ==========================================================================

  initial begin
    word_t va;
    word_t vb;
    int    base;
    instr       = '0;
    errCount    = 0;
    cycleCount  = 0;
    checkActive = 1'b0;
    buildDone   = 1'b0;
    seed        = 32'hb79;
    emitPtr     = 0;
    mPc         = '0;
    expPc       = '0;
    expWbEn     = 1'b0;
    expWbAddr   = '0;
    expWbData   = '0;
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) mMem[i] = '0;

    // plain no-ops, pc walks by 4
    repeat (4) emit('0);
    markTest("reset");

    // jal to the next slot puts pc+4 in r31, slt turns it into one
    emit(encodeJ(OP_JAL, emitPtr + 1));
    emit(encodeR(0, 31, ONE_REG, 0, FN_SLT));
    for (int i = 0; i < 3; i++) begin
      va = $random(seed);
      vb = $random(seed);
      loadConst(2, va);
      loadConst(3, vb);
      emit(encodeR(2, 3, 4, 0, FN_ADD));
      emit(encodeR(2, 3, 5, 0, FN_SUB));
      emit(encodeR(2, 3, 6, 0, FN_AND));
      emit(encodeR(2, 3, 7, 0, FN_OR));
      emit(encodeR(2, 3, 8, 0, FN_SLT));
      emit(encodeR(3, 2, 9, 0, FN_SLT));
    end
    // equal operands, slt gives zero
    emit(encodeR(2, 2, 10, 0, FN_SLT));
    markTest("arith");

    // top and bottom bits set so every distance shows
    va = $random(seed);
    loadConst(10, va | 32'h8000_0001);
    for (int i = 0; i < 32; i++) begin
      emit(encodeR(0, 10, 11, i, FN_SLL));
      emit(encodeR(0, 10, 12, i, FN_SRL));
    end
    markTest("shift");

    // words 3, 40, 77, 114 off r0, then word 127 via negative offset
    for (int i = 0; i < 4; i++) begin
      loadConst(13, $random(seed));
      emit(encodeI(OP_SW, 0, 13, (i * 37 + 3) * 4));
    end
    loadConst(14, 32'h200);
    loadConst(13, $random(seed));
    emit(encodeI(OP_SW, 14, 13, -4));
    for (int i = 0; i < 4; i++) emit(encodeI(OP_LW, 0, 15, (i * 37 + 3) * 4));
    emit(encodeI(OP_LW, 14, 16, -4));
    markTest("memory");

    // taken beq skips two slots
    emit(encodeI(OP_BEQ, ONE_REG, ONE_REG, 2));
    emit(encodeR(ONE_REG, ONE_REG, 20, 0, FN_ADD));
    emit(encodeR(ONE_REG, ONE_REG, 20, 0, FN_ADD));
    // not taken, falls into the next slot
    emit(encodeI(OP_BEQ, ONE_REG, 0, 1));
    emit(encodeR(ONE_REG, ONE_REG, 20, 0, FN_ADD));
    // jal to base+2, jr r31 comes back to base+1, j leaves the block
    base = emitPtr;
    emit(encodeJ(OP_JAL, base + 2));
    emit(encodeJ(OP_J, base + 3));
    emit(encodeR(31, 0, 0, 0, FN_JR));
    markTest("control");

    // writes to r0 are dropped, the add from r0 reads zero
    loadConst(22, $random(seed) | 32'h1);
    emit(encodeR(22, 22, 0, 0, FN_ADD));
    emit(encodeR(0, 22, 0, 4, FN_SLL));
    emit(encodeR(0, 0, 23, 0, FN_ADD));
    markTest("zero");
    buildDone = 1'b1;

    if (emitPtr > PROG_WORDS) begin
      errCount++;
      $display("program of %0d words does not fit the store", emitPtr);
    end

    wait (rst === 1'b1);
    for (int i = 0; i < testName.size(); i++) begin
      runBlock(testName[i], testEnd[i]);
    end
    checkActive = 1'b0;
    $display("summary: %0d tests, %0d cycles checked, %0d errors",
             testName.size(), cycleCount, errCount);
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // limit from program length plus reset plus margin
  initial begin
    int limitNs;
    wait (buildDone === 1'b1);
    limitNs = (emitPtr + RESET_CYCLES + 50) * CLK_PERIOD;
    #(limitNs);
    $display("watchdog: run did not finish within %0d ns", limitNs);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/mipsIsaPkg.sv
design/mipsMemPkg.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/mipsCore.sv
design/dataRam.sv
design/mipsSystem.sv
test/clockGen.sv
test/mipsSystemTb.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module mipsSystemTb -f sources.f -o simv
./obj_dir/simv > sim.log 2>&1
cat sim.log
if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation done without failure"
exit 0
